/* source/pgcb_pkg.sv */
package pgcb_pkg;

    // phase width, a value v holds the phase for v+1 cycles
    typedef logic [1:0] pgcb_delay_t;

    // phase down-counter
    // same width as the delay so a width loads straight in
    typedef logic [1:0] pgcb_count_t;

    // sequencer states
    // down path runs isolate -> reset -> pok -> request
    // up path runs the same steps in reverse
    typedef enum logic [3:0] {
        PG_ACTIVE,
        PG_ISOLATE,
        PG_RSTDOWN,
        PG_POKDOWN,
        PG_REQ_OFF,
        PG_OFF,
        PG_REQ_ON,
        PG_POKUP,
        PG_RSTUP,
        PG_DEISOLATE
    } pgcb_state_t;

endpackage

/* source/pgcb_cfg_if.sv */
`timescale 1ns/10ps

// active phase widths, shadow -> sequencer
interface pgcb_cfg_if import pgcb_pkg::*; ();

    // power-down widths
    pgcb_delay_t t_isolate;
    pgcb_delay_t t_rstdown;
    pgcb_delay_t t_pokdown;

    // power-up widths
    pgcb_delay_t t_pokup;
    pgcb_delay_t t_rstup;
    pgcb_delay_t t_deisolate;

    // shadow side owns every width
    modport src (
        output t_isolate, t_rstdown, t_pokdown,
        output t_pokup, t_rstup, t_deisolate
    );

    // sequencer only reads
    modport dst (
        input t_isolate, t_rstdown, t_pokdown,
        input t_pokup, t_rstup, t_deisolate
    );

endinterface

/* source/pgcb_cfg_shadow.sv */
`timescale 1ns/10ps

module pgcb_cfg_shadow import pgcb_pkg::*; (
    input  logic           pgcb_clk,
    input  logic           rst_n,
    input  logic           cfg_load,
    input  pgcb_delay_t    cfg_isolate,
    input  pgcb_delay_t    cfg_rstdown,
    input  pgcb_delay_t    cfg_pokdown,
    input  pgcb_delay_t    cfg_pokup,
    input  pgcb_delay_t    cfg_rstup,
    input  pgcb_delay_t    cfg_deisolate,
    input  logic           idle,
    input  logic           pwrgate_active,
    pgcb_cfg_if.src        cfg
);

    // slot 0 isolate ... slot 5 deisolate
    pgcb_delay_t [5:0] cfg_in;
    pgcb_delay_t [5:0] act_q;
    pgcb_delay_t [5:0] pend_q;
    logic              pend_vld;
    logic              window;

    // domain powered and settled, no sequence can be running
    assign window = idle && !pwrgate_active;

    assign cfg_in = {cfg_deisolate, cfg_rstup, cfg_pokup, cfg_pokdown, cfg_rstdown, cfg_isolate};

    // commit path
    // a fresh load in the window wins over an older pending copy
    always_ff @(posedge pgcb_clk or negedge rst_n) begin
        if (!rst_n) begin
            act_q    <= '1;
            pend_vld <= 1'b0;
        end else if (window && cfg_load) begin
            act_q    <= cfg_in;
            pend_vld <= 1'b0;
        end else if (window && pend_vld) begin
            act_q    <= pend_q;
            pend_vld <= 1'b0;
        end else if (cfg_load) begin
            pend_vld <= 1'b1;
        end
    end

    // pending copy, newest strobe overwrites
    always_ff @(posedge pgcb_clk) begin
        if (cfg_load) begin
            pend_q <= cfg_in;
        end
    end

    assign cfg.t_isolate   = act_q[0];
    assign cfg.t_rstdown   = act_q[1];
    assign cfg.t_pokdown   = act_q[2];
    assign cfg.t_pokup     = act_q[3];
    assign cfg.t_rstup     = act_q[4];
    assign cfg.t_deisolate = act_q[5];

    // widths frozen for the whole gated period, sequencer idle flag included
    a_cfg_frozen: assert property (@(posedge pgcb_clk) disable iff (!rst_n)
        pwrgate_active |-> $stable(act_q))
        else $error("active widths changed while gating");

endmodule

/* source/pgcb_sequencer.sv */
`timescale 1ns/10ps

module pgcb_sequencer import pgcb_pkg::*; #(
    parameter bit DEF_PWRON = 1'b1
) (
    input  logic      pgcb_clk,
    input  logic      rst_n,
    input  logic      sleep_req,
    input  logic      wake,
    input  logic      pg_disable,
    pgcb_cfg_if.dst   cfg,
    input  logic      pg_ack_b,
    output logic      pg_req_b,
    output logic      isol_b,
    output logic      rst_b,
    output logic      pok,
    output logic      pwrgate_active,
    output logic      power_off,
    output logic      idle
);

    pgcb_state_t state;
    pgcb_count_t cnt;
    logic        ack_q;
    logic        go_down;
    logic        cnt_done;
    logic        ack_match;

    // wake beats sleep, disable only blocks entry to power down
    assign go_down   = sleep_req && !pg_disable && !wake;
    assign cnt_done  = (cnt == '0);
    // ack seen one cycle late through ack_q
    assign ack_match = (ack_q == pg_req_b);

    // settled in a stable state with nothing about to move it
    assign idle = ((state == PG_ACTIVE) && !go_down) || ((state == PG_OFF) && !wake);

    // outputs change on the state edge, so the order follows the state order
    always_ff @(posedge pgcb_clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= DEF_PWRON ? PG_ACTIVE : PG_OFF;
            cnt            <= '0;
            ack_q          <= DEF_PWRON;
            pg_req_b       <= DEF_PWRON;
            isol_b         <= DEF_PWRON;
            rst_b          <= DEF_PWRON;
            pok            <= DEF_PWRON;
            pwrgate_active <= 1'b0;
            power_off      <= !DEF_PWRON;
        end else begin
            ack_q <= pg_ack_b;
            case (state)
                PG_ACTIVE: begin
                    if (go_down) begin
                        state          <= PG_ISOLATE;
                        cnt            <= cfg.t_isolate;
                        pwrgate_active <= 1'b1;
                    end
                end
                // down path
                PG_ISOLATE: begin
                    if (cnt_done) begin
                        state  <= PG_RSTDOWN;
                        cnt    <= cfg.t_rstdown;
                        isol_b <= 1'b0;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                PG_RSTDOWN: begin
                    if (cnt_done) begin
                        state <= PG_POKDOWN;
                        cnt   <= cfg.t_pokdown;
                        rst_b <= 1'b0;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                PG_POKDOWN: begin
                    // pok drops and the gating request goes out together
                    if (cnt_done) begin
                        state    <= PG_REQ_OFF;
                        pok      <= 1'b0;
                        pg_req_b <= 1'b0;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                PG_REQ_OFF: begin
                    // wait as long as the controller needs
                    if (ack_match) begin
                        state     <= PG_OFF;
                        power_off <= 1'b1;
                    end
                end
                PG_OFF: begin
                    if (wake) begin
                        state     <= PG_REQ_ON;
                        pg_req_b  <= 1'b1;
                        power_off <= 1'b0;
                    end
                end
                // up path
                PG_REQ_ON: begin
                    if (ack_match) begin
                        state <= PG_POKUP;
                        cnt   <= cfg.t_pokup;
                    end
                end
                PG_POKUP: begin
                    if (cnt_done) begin
                        state <= PG_RSTUP;
                        cnt   <= cfg.t_rstup;
                        pok   <= 1'b1;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                PG_RSTUP: begin
                    if (cnt_done) begin
                        state <= PG_DEISOLATE;
                        cnt   <= cfg.t_deisolate;
                        rst_b <= 1'b1;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                PG_DEISOLATE: begin
                    // isolation release closes the sequence
                    if (cnt_done) begin
                        state          <= PG_ACTIVE;
                        isol_b         <= 1'b1;
                        pwrgate_active <= 1'b0;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    state <= PG_ACTIVE;
                end
            endcase
        end
    end

    // no power-ok on a domain held in reset while gated
    a_off_pok: assert property (@(posedge pgcb_clk) disable iff (!rst_n)
        (state == PG_OFF) |-> (!pok || rst_b))
        else $error("pok high with rst_b low in PG_OFF");

    // isolation must cover every cycle without power-ok
    a_isol_pok: assert property (@(posedge pgcb_clk) disable iff (!rst_n)
        !pok |-> !isol_b)
        else $error("isol_b high while pok low");

    a_req_chg: assert property (@(posedge pgcb_clk) disable iff (!rst_n)
        $changed(pg_req_b) |-> (state inside {PG_REQ_OFF, PG_REQ_ON}))
        else $error("pg_req_b moved outside a request state");

endmodule

/* source/pmc_responder.sv */
`timescale 1ns/10ps

module pmc_responder #(
    parameter bit DEF_PWRON = 1'b1,
    parameter int ACK_DELAY = 8
) (
    input  logic pgcb_clk,
    input  logic rst_n,
    input  logic pg_req_b,
    output logic pg_ack_b
);

    // wide enough to hold ACK_DELAY-1
    localparam int CW = (ACK_DELAY > 1) ? $clog2(ACK_DELAY) : 1;

    logic [CW-1:0] cnt;
    logic          differ;
    logic          cnt_hit;

    assign differ  = (pg_req_b != pg_ack_b);
    assign cnt_hit = (cnt == CW'(ACK_DELAY - 1));

    // ack follows the request ACK_DELAY cycles after its edge
    always_ff @(posedge pgcb_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= '0;
            pg_ack_b <= DEF_PWRON;
        end else if (differ) begin
            if (cnt_hit) begin
                pg_ack_b <= pg_req_b;
                cnt      <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end else begin
            // request back at the old level, start over
            cnt <= '0;
        end
    end

    // an ack edge answers a request that held its new level for ACK_DELAY cycles
    a_ack_answers: assert property (@(posedge pgcb_clk) disable iff (!rst_n)
        $changed(pg_ack_b) |-> $past(differ) && ($past(pg_req_b, ACK_DELAY) == pg_ack_b))
        else $error("pg_ack_b moved before the request held for ACK_DELAY cycles");

endmodule

/* source/pgcb_subsys.sv */
`timescale 1ns/10ps

module pgcb_subsys import pgcb_pkg::*; #(
    parameter bit DEF_PWRON = 1'b1,
    parameter int ACK_DELAY = 8
) (
    input  logic        pgcb_clk,
    input  logic        rst_n,
    input  logic        sleep_req,
    input  logic        wake,
    input  logic        pg_disable,
    input  logic        cfg_load,
    input  pgcb_delay_t cfg_isolate,
    input  pgcb_delay_t cfg_rstdown,
    input  pgcb_delay_t cfg_pokdown,
    input  pgcb_delay_t cfg_pokup,
    input  pgcb_delay_t cfg_rstup,
    input  pgcb_delay_t cfg_deisolate,
    output logic        isol_b,
    output logic        rst_b,
    output logic        pok,
    output logic        pwrgate_active,
    output logic        power_off,
    output logic        idle
);

    // gating handshake, kept inside the subsystem
    logic pg_req_b;
    logic pg_ack_b;

    pgcb_cfg_if cfg_if ();

    // config window depends on the sequencer's own status
    pgcb_cfg_shadow shadow_i (
        .pgcb_clk       (pgcb_clk),
        .rst_n          (rst_n),
        .cfg_load       (cfg_load),
        .cfg_isolate    (cfg_isolate),
        .cfg_rstdown    (cfg_rstdown),
        .cfg_pokdown    (cfg_pokdown),
        .cfg_pokup      (cfg_pokup),
        .cfg_rstup      (cfg_rstup),
        .cfg_deisolate  (cfg_deisolate),
        .idle           (idle),
        .pwrgate_active (pwrgate_active),
        .cfg            (cfg_if.src)
    );

    pgcb_sequencer #(
        .DEF_PWRON (DEF_PWRON)
    ) seq_i (
        .pgcb_clk       (pgcb_clk),
        .rst_n          (rst_n),
        .sleep_req      (sleep_req),
        .wake           (wake),
        .pg_disable     (pg_disable),
        .cfg            (cfg_if.dst),
        .pg_ack_b       (pg_ack_b),
        .pg_req_b       (pg_req_b),
        .isol_b         (isol_b),
        .rst_b          (rst_b),
        .pok            (pok),
        .pwrgate_active (pwrgate_active),
        .power_off      (power_off),
        .idle           (idle)
    );

    // power controller stand-in
    pmc_responder #(
        .DEF_PWRON (DEF_PWRON),
        .ACK_DELAY (ACK_DELAY)
    ) pmc_i (
        .pgcb_clk (pgcb_clk),
        .rst_n    (rst_n),
        .pg_req_b (pg_req_b),
        .pg_ack_b (pg_ack_b)
    );

endmodule

/* tb/pgcb_tb.sv */
`timescale 1ns/10ps

module pgcb_tb import pgcb_pkg::*; ();

    localparam int ACK_DELAY = 8;
    localparam int MAX_TESTS = 32;
    // op, six widths, three expected levels
    localparam int NF = 10;

    localparam logic [3:0] OP_LOAD    = 4'h0;
    localparam logic [3:0] OP_SLEEP   = 4'h1;
    localparam logic [3:0] OP_WAKE    = 4'h2;
    localparam logic [3:0] OP_DISABLE = 4'h3;
    localparam logic [3:0] OP_END     = 4'hf;

    // output selectors
    localparam int S_PGA  = 0;
    localparam int S_ISOL = 1;
    localparam int S_RST  = 2;
    localparam int S_POK  = 3;
    localparam int S_POFF = 4;

    logic        pgcb_clk;
    logic        rst_n;
    logic        sleep_req;
    logic        wake;
    logic        pg_disable;
    logic        cfg_load;
    pgcb_delay_t cfg_isolate;
    pgcb_delay_t cfg_rstdown;
    pgcb_delay_t cfg_pokdown;
    pgcb_delay_t cfg_pokup;
    pgcb_delay_t cfg_rstup;
    pgcb_delay_t cfg_deisolate;
    logic        isol_b;
    logic        rst_b;
    logic        pok;
    logic        pwrgate_active;
    logic        power_off;
    logic        idle;

    logic [3:0]  stim_mem [0:MAX_TESTS*NF-1];
    // widths the DUT should run with, and a copy held back while gated
    pgcb_delay_t mdl_act [6];
    pgcb_delay_t mdl_pend [6];
    logic        pend_vld;
    logic        powered;
    int          err_cnt;
    int          pass_cnt;
    int          fail_cnt;
    int          n_tests;
    int          cycles = 0;
    int          cycle_limit = 0;

    pgcb_subsys #(
        .DEF_PWRON (1'b1),
        .ACK_DELAY (ACK_DELAY)
    ) dut_i (.*);

    always #10 pgcb_clk = ~pgcb_clk;

    // watchdog, limit set once the stimulus is read
    always @(posedge pgcb_clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("run hung, still waiting on the DUT after %0d cycles", cycles);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic sample_sig(input int sel);
        case (sel)
            S_PGA:   return pwrgate_active;
            S_ISOL:  return isol_b;
            S_RST:   return rst_b;
            S_POK:   return pok;
            default: return power_off;
        endcase
    endfunction

    function automatic string op_name(input logic [3:0] op);
        case (op)
            OP_LOAD:  return "load";
            OP_SLEEP: return "sleep";
            OP_WAKE:  return "wake";
            default:  return "disable";
        endcase
    endfunction

    task automatic check_int(input string what, input int got, input int want);
        assert (got == want) else begin
            $display("[FAIL] %0t: %s after %0d cycles, expected %0d", $time, what, got, want);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic want);
        assert (got === want) else begin
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, want);
            err_cnt++;
        end
    endtask

    // count cycles until the output reaches level
    // sampled on the falling edge, away from the DUT's own edge
    task automatic expect_edge(input int sel, input logic level, input int want,
                               input string what);
        int n;
        n = 0;
        do begin
            @(negedge pgcb_clk);
            n++;
        end while (sample_sig(sel) !== level);
        check_int(what, n, want);
    endtask

    // one-cycle strobe, returns just after the edge that samples it
    task automatic strobe(input logic [3:0] op);
        @(posedge pgcb_clk);
        case (op)
            OP_LOAD:  cfg_load <= 1'b1;
            OP_SLEEP: sleep_req <= 1'b1;
            default:  wake <= 1'b1;
        endcase
        @(posedge pgcb_clk);
        cfg_load  <= 1'b0;
        sleep_req <= 1'b0;
        wake      <= 1'b0;
    endtask

    task automatic run_load(input int base);
        pgcb_delay_t w [6];
        for (int i = 0; i < 6; i++) begin
            w[i] = stim_mem[base + 1 + i][1:0];
        end
        @(posedge pgcb_clk);
        cfg_isolate   <= w[0];
        cfg_rstdown   <= w[1];
        cfg_pokdown   <= w[2];
        cfg_pokup     <= w[3];
        cfg_rstup     <= w[4];
        cfg_deisolate <= w[5];
        strobe(OP_LOAD);
        // gated domain keeps its widths until it is back up
        if (powered) begin
            mdl_act = w;
        end else begin
            mdl_pend = w;
            pend_vld = 1'b1;
        end
    endtask

    task automatic run_sleep();
        strobe(OP_SLEEP);
        expect_edge(S_PGA, 1'b1, 1, "pwrgate_active rise");
        expect_edge(S_ISOL, 1'b0, int'(mdl_act[0]) + 1, "isol_b fall");
        expect_edge(S_RST, 1'b0, int'(mdl_act[1]) + 1, "rst_b fall");
        expect_edge(S_POK, 1'b0, int'(mdl_act[2]) + 1, "pok fall");
        // ack latency plus one cycle to see it
        expect_edge(S_POFF, 1'b1, ACK_DELAY + 2, "power_off rise");
        powered = 1'b0;
    endtask

    task automatic run_wake();
        strobe(OP_WAKE);
        expect_edge(S_POFF, 1'b0, 1, "power_off fall");
        // handshake first, then the pok phase
        expect_edge(S_POK, 1'b1, ACK_DELAY + 2 + int'(mdl_act[3]) + 1, "pok rise");
        expect_edge(S_RST, 1'b1, int'(mdl_act[4]) + 1, "rst_b rise");
        expect_edge(S_ISOL, 1'b1, int'(mdl_act[5]) + 1, "isol_b rise");
        check_bit("pwrgate_active at isol_b rise", pwrgate_active, 1'b0);
        powered = 1'b1;
        if (pend_vld) begin
            mdl_act  = mdl_pend;
            pend_vld = 1'b0;
        end
    endtask

    task automatic run_disable();
        logic [4:0] snap;
        snap = {pwrgate_active, isol_b, rst_b, pok, power_off};
        @(posedge pgcb_clk);
        pg_disable <= 1'b1;
        strobe(OP_SLEEP);
        repeat (20) begin
            @(negedge pgcb_clk);
            check_bit("outputs held under pg_disable",
                      ({pwrgate_active, isol_b, rst_b, pok, power_off} == snap), 1'b1);
        end
        @(posedge pgcb_clk);
        pg_disable <= 1'b0;
    endtask

    task automatic check_levels(input int base);
        check_bit("power_off", power_off, stim_mem[base + 7][0]);
        check_bit("pok", pok, stim_mem[base + 8][0]);
        check_bit("isol_b", isol_b, stim_mem[base + 9][0]);
    endtask

    task automatic close_test(input int num, input string what, input int err_before);
        if (err_cnt == err_before) begin
            pass_cnt++;
            $display("test %0d %s: ok", num, what);
        end else begin
            fail_cnt++;
            $display("test %0d %s: %0d errors", num, what, err_cnt - err_before);
        end
    endtask

    initial begin
        int base;
        int err_before;
        pgcb_clk      = 1'b0;
        rst_n         = 1'b0;
        sleep_req     = 1'b0;
        wake          = 1'b0;
        pg_disable    = 1'b0;
        cfg_load      = 1'b0;
        cfg_isolate   = '0;
        cfg_rstdown   = '0;
        cfg_pokdown   = '0;
        cfg_pokup     = '0;
        cfg_rstup     = '0;
        cfg_deisolate = '0;
        err_cnt       = 0;
        pass_cnt      = 0;
        fail_cnt      = 0;
        pend_vld      = 1'b0;
        powered       = 1'b1;
        // shadow comes out of reset with all-ones widths
        for (int i = 0; i < 6; i++) begin
            mdl_act[i]  = '1;
            mdl_pend[i] = '1;
        end
        $readmemh("tb/pgcb_stim.txt", stim_mem);
        n_tests = 0;
        while (n_tests < MAX_TESTS && stim_mem[n_tests * NF] != OP_END) begin
            n_tests++;
        end
        cycle_limit = 40 * n_tests + 16 * 5 * 4 * (ACK_DELAY + 2);

        repeat (16) @(posedge pgcb_clk);
        rst_n <= 1'b1;

        // levels straight out of reset
        @(negedge pgcb_clk);
        err_before = err_cnt;
        check_bit("pwrgate_active", pwrgate_active, 1'b0);
        check_bit("idle", idle, 1'b1);
        check_bit("isol_b", isol_b, 1'b1);
        check_bit("rst_b", rst_b, 1'b1);
        check_bit("pok", pok, 1'b1);
        close_test(0, "reset", err_before);

        for (int t = 0; t < n_tests; t++) begin
            base       = t * NF;
            err_before = err_cnt;
            repeat (3) @(negedge pgcb_clk);
            case (stim_mem[base])
                OP_LOAD:    run_load(base);
                OP_SLEEP:   run_sleep();
                OP_WAKE:    run_wake();
                OP_DISABLE: run_disable();
                default: begin
                    $display("unknown operation code %h in test %0d", stim_mem[base], t + 1);
                    err_cnt++;
                end
            endcase
            // settled levels
            repeat (2) @(negedge pgcb_clk);
            check_levels(base);
            close_test(t + 1, op_name(stim_mem[base]), err_before);
        end

        if (n_tests == 0) begin
            $display("no tests found in the stimulus file");
            fail_cnt++;
        end
        $display("tests ok: %0d, tests with errors: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* tb/pgcb_stim.txt */
// op t_isolate t_rstdown t_pokdown t_pokup t_rstup t_deisolate power_off pok isol_b
// op 0 load, 1 sleep, 2 wake, 3 disable, f end of tests
1 0 0 0 0 0 0 1 0 0
2 0 0 0 0 0 0 0 1 1
0 1 0 2 1 2 0 0 1 1
1 0 0 0 0 0 0 1 0 0
2 0 0 0 0 0 0 0 1 1
3 0 0 0 0 0 0 0 1 1
0 3 2 1 0 1 2 0 1 1
1 0 0 0 0 0 0 1 0 0
// load while gated, held back until power-up ends
0 0 1 0 2 0 1 1 0 0
2 0 0 0 0 0 0 0 1 1
1 0 0 0 0 0 0 1 0 0
2 0 0 0 0 0 0 0 1 1
0 0 0 0 0 0 0 0 1 1
1 0 0 0 0 0 0 1 0 0
2 0 0 0 0 0 0 0 1 1
f 0 0 0 0 0 0 0 0 0

/* vlog.f */
source/pgcb_pkg.sv
source/pgcb_cfg_if.sv
source/pgcb_cfg_shadow.sv
source/pgcb_sequencer.sv
source/pmc_responder.sv
source/pgcb_subsys.sv
tb/pgcb_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the pgcb testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module pgcb_tb -o pgcb_sim \
    > build.log 2>&1 \
    && ./obj_dir/pgcb_sim > sim.log 2>&1 \
    || echo "build or simulation stopped with an error, see build.log and sim.log"
grep -qx "test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
